// ==== filelist.f ====
src/rv_decode_pkg.sv
src/decode_lane.sv
src/fetch_pair_queue.sv
src/decode_stage.sv
src/rv_decode_top.sv
verification/tb_rv_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_rv_decode \
    -f filelist.f -o sim_tb

# The simulator status is not trusted, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log || true

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1

// ==== verification/tb_rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode;

    localparam int accept_timeout = 200;  // Cycles per fetch handshake
    localparam int drain_timeout  = 300;
    localparam logic [6:0] legal_opc [10] = '{
        rv_decode_pkg::opc_lui, rv_decode_pkg::opc_auipc, rv_decode_pkg::opc_jal,
        rv_decode_pkg::opc_jalr, rv_decode_pkg::opc_branch, rv_decode_pkg::opc_load,
        rv_decode_pkg::opc_store, rv_decode_pkg::opc_ari_itype, rv_decode_pkg::opc_ari_rtype,
        rv_decode_pkg::opc_csr
    };

    // One decoded lane in the field order of the monitor concatenation
    typedef struct packed {
        logic                               valid;
        logic [rv_decode_pkg::addr_bits-1:0] pc;
        logic [6:0]                         opcode;
        logic [rv_decode_pkg::reg_bits-1:0] rd;
        logic                               has_rd;
        logic [rv_decode_pkg::reg_bits-1:0] rs1;
        logic [rv_decode_pkg::reg_bits-1:0] rs2;
        logic                               src0_is_pc;
        logic                               src1_is_imm;
        logic [rv_decode_pkg::xlen-1:0]     imm;
        logic [2:0]                         alu_op;
        logic [2:0]                         br_cond;
        logic [6:0]                         funct7;
        logic                               is_jump;
    } lane_t;

    logic                                clk, rst_n, flush, fetch_val, decode_rdy, rename_rdy;
    logic [rv_decode_pkg::addr_bits-1:0] inst0_pc, inst1_pc;
    logic [rv_decode_pkg::inst_bits-1:0] inst0, inst1;
    logic                                lane0_valid, lane0_has_rd, lane0_is_jump;
    logic                                lane0_src0_is_pc, lane0_src1_is_imm;
    logic [rv_decode_pkg::addr_bits-1:0] lane0_pc;
    rv_decode_pkg::opcode_e              lane0_opcode;
    logic [rv_decode_pkg::reg_bits-1:0]  lane0_rd, lane0_rs1, lane0_rs2;
    logic [rv_decode_pkg::xlen-1:0]      lane0_imm;
    rv_decode_pkg::alu_op_e              lane0_alu_op;
    rv_decode_pkg::br_cond_e             lane0_br_cond;
    logic [6:0]                          lane0_funct7;
    logic                                lane1_valid, lane1_has_rd, lane1_is_jump;
    logic                                lane1_src0_is_pc, lane1_src1_is_imm;
    logic [rv_decode_pkg::addr_bits-1:0] lane1_pc;
    rv_decode_pkg::opcode_e              lane1_opcode;
    logic [rv_decode_pkg::reg_bits-1:0]  lane1_rd, lane1_rs1, lane1_rs2;
    logic [rv_decode_pkg::xlen-1:0]      lane1_imm;
    rv_decode_pkg::alu_op_e              lane1_alu_op;
    rv_decode_pkg::br_cond_e             lane1_br_cond;
    logic [6:0]                          lane1_funct7;

    lane_t       exp0 [$], exp1 [$];  // Pairs rename has yet to take
    lane_t       e0, e1, g0, g1, r0, r1, r_tmp;
    int          rdy_mode;  // 0 ready, 1 random, 2 stalled
    int unsigned seed_ret;
    logic [31:0] pc_next;

    rv_decode_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // Reporting
    // --------------------
    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        stop_failed();
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("error %s expected %h got %h", name, exp, got);
            stop_failed();
        end
    endtask

    // --------------------
    // Reference decode
    // --------------------
    function automatic lane_t ref_decode(input logic [31:0] pc, input logic [31:0] inst,
                                         input logic in_val);
        lane_t      r;
        logic [2:0] f3;
        r  = '0;
        f3 = inst[14:12];
        if (!in_val)
            return r;
        r.src1_is_imm = 1'b1;
        case (inst[6:0])
            rv_decode_pkg::opc_lui: begin
                r.has_rd = 1'b1;
                r.imm    = {inst[31:12], 12'h000};
            end
            rv_decode_pkg::opc_auipc: begin
                r.has_rd     = 1'b1;
                r.src0_is_pc = 1'b1;
                r.imm        = {inst[31:12], 12'h000};
            end
            rv_decode_pkg::opc_jal: begin
                r.has_rd     = 1'b1;
                r.is_jump    = 1'b1;
                r.src0_is_pc = 1'b1;
                r.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rv_decode_pkg::opc_jalr: begin
                r.has_rd  = 1'b1;
                r.is_jump = 1'b1;
                r.imm     = {{20{inst[31]}}, inst[31:20]};
            end
            rv_decode_pkg::opc_branch: begin
                r.src0_is_pc = 1'b1;
                r.br_cond    = f3;
                r.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_decode_pkg::opc_load, rv_decode_pkg::opc_ari_itype: begin
                r.has_rd = 1'b1;
                r.alu_op = f3;
                r.imm    = {{20{inst[31]}}, inst[31:20]};
            end
            rv_decode_pkg::opc_store: begin
                r.alu_op = f3;
                r.imm    = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv_decode_pkg::opc_ari_rtype: begin
                r.has_rd      = 1'b1;
                r.src1_is_imm = 1'b0;
                r.alu_op      = f3;
            end
            rv_decode_pkg::opc_csr: ;
            default: return '0;  // Illegal slot
        endcase
        r.valid  = 1'b1;
        r.pc     = pc;
        r.opcode = inst[6:0];
        r.rd     = inst[11:7];
        r.rs1    = inst[19:15];
        r.rs2    = inst[24:20];
        r.funct7 = inst[31:25];
        return r;
    endfunction

    task automatic compare_lane(input string lane, input lane_t e, input lane_t g);
        check_val({lane, "_valid"}, 32'(e.valid), 32'(g.valid));
        check_val({lane, "_pc"}, e.pc, g.pc);
        check_val({lane, "_opcode"}, 32'(e.opcode), 32'(g.opcode));
        check_val({lane, "_rd"}, 32'(e.rd), 32'(g.rd));
        check_val({lane, "_has_rd"}, 32'(e.has_rd), 32'(g.has_rd));
        check_val({lane, "_rs1"}, 32'(e.rs1), 32'(g.rs1));
        check_val({lane, "_rs2"}, 32'(e.rs2), 32'(g.rs2));
        check_val({lane, "_src0_is_pc"}, 32'(e.src0_is_pc), 32'(g.src0_is_pc));
        check_val({lane, "_src1_is_imm"}, 32'(e.src1_is_imm), 32'(g.src1_is_imm));
        check_val({lane, "_imm"}, e.imm, g.imm);
        check_val({lane, "_alu_op"}, 32'(e.alu_op), 32'(g.alu_op));
        check_val({lane, "_br_cond"}, 32'(e.br_cond), 32'(g.br_cond));
        check_val({lane, "_funct7"}, 32'(e.funct7), 32'(g.funct7));
        check_val({lane, "_is_jump"}, 32'(e.is_jump), 32'(g.is_jump));
    endtask

    // Scoreboard sampled at the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (rename_rdy && (lane0_valid || lane1_valid)) begin  // Rename takes the pair
                if (exp0.size() == 0)
                    abort_run("a valid pair was shown that was never sent");
                e0 = exp0.pop_front();
                e1 = exp1.pop_front();
                g0 = {lane0_valid, lane0_pc, lane0_opcode, lane0_rd, lane0_has_rd, lane0_rs1,
                      lane0_rs2, lane0_src0_is_pc, lane0_src1_is_imm, lane0_imm, lane0_alu_op,
                      lane0_br_cond, lane0_funct7, lane0_is_jump};
                g1 = {lane1_valid, lane1_pc, lane1_opcode, lane1_rd, lane1_has_rd, lane1_rs1,
                      lane1_rs2, lane1_src0_is_pc, lane1_src1_is_imm, lane1_imm, lane1_alu_op,
                      lane1_br_cond, lane1_funct7, lane1_is_jump};
                compare_lane("lane0", e0, g0);
                compare_lane("lane1", e1, g1);
            end
            if (fetch_val && decode_rdy && !flush) begin
                r0 = ref_decode(inst0_pc, inst0, 1'b1);
                r1 = ref_decode(inst1_pc, inst1, 1'b1);
                if (r0.valid || r1.valid) begin  // All-illegal pair never shows
                    exp0.push_back(r0);
                    exp1.push_back(r1);
                end
            end
            if (flush) begin
                exp0.delete();
                exp1.delete();
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic next_cycle();
        @(negedge clk);
        case (rdy_mode)
            0:       rename_rdy = 1'b1;
            1:       rename_rdy = (($urandom % 4) != 0);
            default: rename_rdy = 1'b0;
        endcase
    endtask

    function automatic logic [31:0] rand_inst();
        logic [31:0] bits;
        int unsigned pick;
        bits = $urandom;
        pick = $urandom % 12;
        if (pick < 10)
            bits[6:0] = legal_opc[pick];  // Otherwise mostly illegal
        return bits;
    endfunction

    task automatic send_pair(input logic [31:0] pc0, input logic [31:0] i0,
                             input logic [31:0] pc1, input logic [31:0] i1);
        int waited;
        bit taken;
        fetch_val = 1'b1;
        inst0_pc  = pc0;
        inst0     = i0;
        inst1_pc  = pc1;
        inst1     = i1;
        waited    = 0;
        taken     = 1'b0;
        while (!taken) begin
            taken = decode_rdy;  // Stable until the next rising edge
            next_cycle();
            waited++;
            if (!taken && waited >= accept_timeout)
                abort_run("fetch pair was not accepted before the timeout");
        end
        fetch_val = 1'b0;
    endtask

    task automatic send_rand_pair();
        send_pair(pc_next, rand_inst(), pc_next + 32'd4, rand_inst());
        pc_next = pc_next + 32'd8;
    endtask

    task automatic drain();
        int waited;
        rdy_mode = 0;
        waited   = 0;
        while (exp0.size() != 0) begin
            next_cycle();
            waited++;
            if (waited >= drain_timeout)
                abort_run("sent pairs did not reach rename before the timeout");
        end
        repeat (rv_decode_pkg::pair_queue_depth) next_cycle();  // Pop any all-illegal pair
    endtask

    initial begin
        seed_ret   = $urandom(32'hbc02_e1f5);
        rst_n      = 1'b0;
        flush      = 1'b0;
        fetch_val  = 1'b0;
        inst0_pc   = '0;
        inst0      = '0;
        inst1_pc   = '0;
        inst1      = '0;
        rename_rdy = 1'b1;
        rdy_mode   = 0;
        pc_next    = 32'h0000_2000;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        next_cycle();

        check_val("decode_rdy", 32'd1, 32'(decode_rdy));
        check_val("lane0_valid", 32'd0, 32'(lane0_valid));
        check_val("lane1_valid", 32'd0, 32'(lane1_valid));

        // Hand-decoded immediates keep the model honest
        r_tmp = ref_decode(32'h0, 32'hfe5218e3, 1'b1);  // bne x4, x5, -16
        check_val("model_b_imm", 32'hffff_fff0, r_tmp.imm);
        r_tmp = ref_decode(32'h0, 32'hff9ff0ef, 1'b1);  // jal x1, -8
        check_val("model_j_imm", 32'hffff_fff8, r_tmp.imm);
        r_tmp = ref_decode(32'h0, 32'h0081aa23, 1'b1);  // sw x8, 20(x3)
        check_val("model_s_imm", 32'd20, r_tmp.imm);

        // --------------------
        // Directed formats
        // --------------------
        send_pair(32'h100, 32'habcde2b7, 32'h104, 32'h12345317);  // lui, auipc
        send_pair(32'h108, 32'hff9ff0ef, 32'h10c, 32'h00c08067);  // jal, jalr
        send_pair(32'h110, 32'hffc12383, 32'h114, 32'h0081aa23);  // lw, sw
        send_pair(32'h118, 32'hfe5218e3, 32'h11c, 32'h40b504b3);  // bne, sub
        send_pair(32'h120, 32'hfff68613, 32'h124, 32'h30011073);  // addi -1, csrrw
        send_pair(32'h128, 32'h0000000f, 32'h12c, 32'hfff68613);  // fence is illegal
        send_pair(32'h130, 32'h12345317, 32'h134, 32'h00004501);  // compressed lane1
        drain();

        // Queue fills while rename stalls
        rdy_mode = 2;
        next_cycle();
        repeat (rv_decode_pkg::pair_queue_depth) send_rand_pair();
        check_val("decode_rdy", 32'd0, 32'(decode_rdy));
        drain();

        // --------------------
        // Random stream
        // --------------------
        rdy_mode = 1;
        repeat (500) begin
            repeat ($urandom % 3) next_cycle();
            send_rand_pair();
        end
        drain();

        // Flush with pairs in flight drops the offered pair
        rdy_mode = 1;
        repeat (12) send_rand_pair();
        flush     = 1'b1;
        fetch_val = 1'b1;
        inst0     = 32'hfff68613;
        inst1     = 32'h40b504b3;
        next_cycle();
        flush     = 1'b0;
        fetch_val = 1'b0;
        check_val("lane0_valid", 32'd0, 32'(lane0_valid));
        check_val("lane1_valid", 32'd0, 32'(lane1_valid));
        check_val("decode_rdy", 32'd1, 32'(decode_rdy));
        repeat (40) send_rand_pair();
        drain();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/rv_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    // Fetch side
    input  logic                                fetch_val,
    output logic                                decode_rdy,
    input  logic [rv_decode_pkg::addr_bits-1:0] inst0_pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] inst0,
    input  logic [rv_decode_pkg::addr_bits-1:0] inst1_pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] inst1,
    // Rename side
    input  logic                                rename_rdy,
    output logic                                lane0_valid, lane0_has_rd, lane0_is_jump,
    output logic                                lane0_src0_is_pc, lane0_src1_is_imm,
    output logic [rv_decode_pkg::addr_bits-1:0] lane0_pc,
    output rv_decode_pkg::opcode_e              lane0_opcode,
    output logic [rv_decode_pkg::reg_bits-1:0]  lane0_rd, lane0_rs1, lane0_rs2,
    output logic [rv_decode_pkg::xlen-1:0]      lane0_imm,
    output rv_decode_pkg::alu_op_e              lane0_alu_op,
    output rv_decode_pkg::br_cond_e             lane0_br_cond,
    output logic [6:0]                          lane0_funct7,
    output logic                                lane1_valid, lane1_has_rd, lane1_is_jump,
    output logic                                lane1_src0_is_pc, lane1_src1_is_imm,
    output logic [rv_decode_pkg::addr_bits-1:0] lane1_pc,
    output rv_decode_pkg::opcode_e              lane1_opcode,
    output logic [rv_decode_pkg::reg_bits-1:0]  lane1_rd, lane1_rs1, lane1_rs2,
    output logic [rv_decode_pkg::xlen-1:0]      lane1_imm,
    output rv_decode_pkg::alu_op_e              lane1_alu_op,
    output rv_decode_pkg::br_cond_e             lane1_br_cond,
    output logic [6:0]                          lane1_funct7
);

    // Queue head towards the decode stage
    logic                                queue_full;
    logic                                q_val, q_pop;
    logic [rv_decode_pkg::addr_bits-1:0] q_inst0_pc, q_inst1_pc;
    logic [rv_decode_pkg::inst_bits-1:0] q_inst0, q_inst1;

    assign decode_rdy = ~queue_full;

    fetch_pair_queue pair_queue0 (
        .clk,
        .rst_n,
        .flush,
        .push(fetch_val),
        .in_inst0_pc(inst0_pc),
        .in_inst0(inst0),
        .in_inst1_pc(inst1_pc),
        .in_inst1(inst1),
        .pop(q_pop),
        .full(queue_full),
        .q_val,
        .q_inst0_pc,
        .q_inst0,
        .q_inst1_pc,
        .q_inst1
    );

    // Every stage port has a net of the same name here
    decode_stage decode_stage0 (.*);

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                rename_rdy,
    input  logic                                q_val,
    input  logic [rv_decode_pkg::addr_bits-1:0] q_inst0_pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] q_inst0,
    input  logic [rv_decode_pkg::addr_bits-1:0] q_inst1_pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] q_inst1,
    output logic                                q_pop,
    // Lane 0
    output logic                                lane0_valid, lane0_has_rd, lane0_is_jump,
    output logic                                lane0_src0_is_pc, lane0_src1_is_imm,
    output logic [rv_decode_pkg::addr_bits-1:0] lane0_pc,
    output rv_decode_pkg::opcode_e              lane0_opcode,
    output logic [rv_decode_pkg::reg_bits-1:0]  lane0_rd, lane0_rs1, lane0_rs2,
    output logic [rv_decode_pkg::xlen-1:0]      lane0_imm,
    output rv_decode_pkg::alu_op_e              lane0_alu_op,
    output rv_decode_pkg::br_cond_e             lane0_br_cond,
    output logic [6:0]                          lane0_funct7,
    // Lane 1
    output logic                                lane1_valid, lane1_has_rd, lane1_is_jump,
    output logic                                lane1_src0_is_pc, lane1_src1_is_imm,
    output logic [rv_decode_pkg::addr_bits-1:0] lane1_pc,
    output rv_decode_pkg::opcode_e              lane1_opcode,
    output logic [rv_decode_pkg::reg_bits-1:0]  lane1_rd, lane1_rs1, lane1_rs2,
    output logic [rv_decode_pkg::xlen-1:0]      lane1_imm,
    output rv_decode_pkg::alu_op_e              lane1_alu_op,
    output rv_decode_pkg::br_cond_e             lane1_br_cond,
    output logic [6:0]                          lane1_funct7
);

    logic                                lane_in_val, load;
    logic                                d0_valid, d0_has_rd, d0_is_jump, d0_src0_pc, d0_src1_imm;
    logic                                d1_valid, d1_has_rd, d1_is_jump, d1_src0_pc, d1_src1_imm;
    logic [rv_decode_pkg::addr_bits-1:0] d0_pc, d1_pc;
    rv_decode_pkg::opcode_e              d0_opcode, d1_opcode;
    logic [rv_decode_pkg::reg_bits-1:0]  d0_rd, d0_rs1, d0_rs2, d1_rd, d1_rs1, d1_rs2;
    logic [rv_decode_pkg::xlen-1:0]      d0_imm, d1_imm;
    rv_decode_pkg::alu_op_e              d0_alu_op, d1_alu_op;
    rv_decode_pkg::br_cond_e             d0_br_cond, d1_br_cond;
    logic [6:0]                          d0_funct7, d1_funct7;

    assign q_pop = q_val & rename_rdy;

    // Lanes read zero when the queue is empty or on flush,
    // so every load of the register is either a pair or a bubble
    assign lane_in_val = q_val & ~flush;
    assign load        = rename_rdy | flush;

    decode_lane lane0 (
        .pc(q_inst0_pc), .inst(q_inst0), .in_val(lane_in_val),
        .valid(d0_valid), .inst_pc(d0_pc), .opcode(d0_opcode),
        .rd(d0_rd), .has_rd(d0_has_rd), .rs1(d0_rs1), .rs2(d0_rs2),
        .src0_is_pc(d0_src0_pc), .src1_is_imm(d0_src1_imm), .imm(d0_imm),
        .alu_op(d0_alu_op), .br_cond(d0_br_cond), .funct7(d0_funct7), .is_jump(d0_is_jump)
    );

    decode_lane lane1 (
        .pc(q_inst1_pc), .inst(q_inst1), .in_val(lane_in_val),
        .valid(d1_valid), .inst_pc(d1_pc), .opcode(d1_opcode),
        .rd(d1_rd), .has_rd(d1_has_rd), .rs1(d1_rs1), .rs2(d1_rs2),
        .src0_is_pc(d1_src0_pc), .src1_is_imm(d1_src1_imm), .imm(d1_imm),
        .alu_op(d1_alu_op), .br_cond(d1_br_cond), .funct7(d1_funct7), .is_jump(d1_is_jump)
    );

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane0_valid <= 1'b0;
            lane1_valid <= 1'b0;
        end else if (load) begin
            lane0_valid <= d0_valid;
            lane1_valid <= d1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin  // Held while rename stalls
            lane0_pc          <= d0_pc;
            lane0_opcode      <= d0_opcode;
            lane0_rd          <= d0_rd;
            lane0_has_rd      <= d0_has_rd;
            lane0_rs1         <= d0_rs1;
            lane0_rs2         <= d0_rs2;
            lane0_src0_is_pc  <= d0_src0_pc;
            lane0_src1_is_imm <= d0_src1_imm;
            lane0_imm         <= d0_imm;
            lane0_alu_op      <= d0_alu_op;
            lane0_br_cond     <= d0_br_cond;
            lane0_funct7      <= d0_funct7;
            lane0_is_jump     <= d0_is_jump;
            lane1_pc          <= d1_pc;
            lane1_opcode      <= d1_opcode;
            lane1_rd          <= d1_rd;
            lane1_has_rd      <= d1_has_rd;
            lane1_rs1         <= d1_rs1;
            lane1_rs2         <= d1_rs2;
            lane1_src0_is_pc  <= d1_src0_pc;
            lane1_src1_is_imm <= d1_src1_imm;
            lane1_imm         <= d1_imm;
            lane1_alu_op      <= d1_alu_op;
            lane1_br_cond     <= d1_br_cond;
            lane1_funct7      <= d1_funct7;
            lane1_is_jump     <= d1_is_jump;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_pair_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pair_queue (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                push,
    input  logic [rv_decode_pkg::addr_bits-1:0] in_inst0_pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] in_inst0,
    input  logic [rv_decode_pkg::addr_bits-1:0] in_inst1_pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] in_inst1,
    input  logic                                pop,
    output logic                                full,
    output logic                                q_val,
    output logic [rv_decode_pkg::addr_bits-1:0] q_inst0_pc,
    output logic [rv_decode_pkg::inst_bits-1:0] q_inst0,
    output logic [rv_decode_pkg::addr_bits-1:0] q_inst1_pc,
    output logic [rv_decode_pkg::inst_bits-1:0] q_inst1
);

    logic [rv_decode_pkg::addr_bits-1:0]     pc0_mem   [rv_decode_pkg::pair_queue_depth];
    logic [rv_decode_pkg::inst_bits-1:0]     inst0_mem [rv_decode_pkg::pair_queue_depth];
    logic [rv_decode_pkg::addr_bits-1:0]     pc1_mem   [rv_decode_pkg::pair_queue_depth];
    logic [rv_decode_pkg::inst_bits-1:0]     inst1_mem [rv_decode_pkg::pair_queue_depth];
    logic [rv_decode_pkg::pair_ptr_bits-1:0] wr_ptr, rd_ptr;
    logic [rv_decode_pkg::pair_cnt_bits-1:0] count;
    logic                                    do_push, do_pop;

    function automatic logic [rv_decode_pkg::pair_ptr_bits-1:0] next_ptr(
        input logic [rv_decode_pkg::pair_ptr_bits-1:0] ptr
    );
        if (ptr == rv_decode_pkg::pair_ptr_bits'(rv_decode_pkg::pair_queue_depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign full    = (count == rv_decode_pkg::pair_cnt_bits'(rv_decode_pkg::pair_queue_depth));
    assign q_val   = (count != '0);
    assign do_push = push & ~full & ~flush;  // Offer at flush edge is dropped
    assign do_pop  = pop & q_val & ~flush;

    // Head is visible as soon as it is written
    assign q_inst0_pc = pc0_mem[rd_ptr];
    assign q_inst0    = inst0_mem[rd_ptr];
    assign q_inst1_pc = pc1_mem[rd_ptr];
    assign q_inst1    = inst1_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc0_mem[wr_ptr]   <= in_inst0_pc;
            inst0_mem[wr_ptr] <= in_inst0;
            pc1_mem[wr_ptr]   <= in_inst1_pc;
            inst1_mem[wr_ptr] <= in_inst1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither, level unchanged
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/decode_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_lane (
    input  logic [rv_decode_pkg::addr_bits-1:0] pc,
    input  logic [rv_decode_pkg::inst_bits-1:0] inst,
    input  logic                                in_val,
    output logic                                valid,
    output logic [rv_decode_pkg::addr_bits-1:0] inst_pc,
    output rv_decode_pkg::opcode_e              opcode,
    output logic [rv_decode_pkg::reg_bits-1:0]  rd,
    output logic                                has_rd,
    output logic [rv_decode_pkg::reg_bits-1:0]  rs1,
    output logic [rv_decode_pkg::reg_bits-1:0]  rs2,
    output logic                                src0_is_pc,
    output logic                                src1_is_imm,
    output logic [rv_decode_pkg::xlen-1:0]      imm,
    output rv_decode_pkg::alu_op_e              alu_op,
    output rv_decode_pkg::br_cond_e             br_cond,
    output logic [6:0]                          funct7,
    output logic                                is_jump
);

    logic [2:0]                     funct3;
    logic [rv_decode_pkg::xlen-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
    logic [rv_decode_pkg::xlen-1:0] imm_sel;
    logic                           known, wr_rd, jump, pc_src, imm_src;
    rv_decode_pkg::alu_op_e         alu_sel;
    rv_decode_pkg::br_cond_e        br_sel;

    assign funct3 = inst[14:12];

    // --------------------
    // Immediate formats
    // --------------------
    assign i_imm = {{(rv_decode_pkg::xlen-12){inst[31]}}, inst[31:20]};
    assign s_imm = {{(rv_decode_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{(rv_decode_pkg::xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{(rv_decode_pkg::xlen-20){inst[31]}}, inst[19:12], inst[20], inst[30:21],
                    1'b0};

    // Per-opcode control
    always_comb begin
        known   = 1'b1;
        wr_rd   = 1'b0;
        jump    = 1'b0;
        pc_src  = 1'b0;
        imm_src = 1'b1;  // Only R-type reads rs2
        imm_sel = '0;
        alu_sel = rv_decode_pkg::add_sub;
        br_sel  = rv_decode_pkg::beq;
        case (inst[6:0])
            rv_decode_pkg::opc_lui: begin
                wr_rd   = 1'b1;
                imm_sel = u_imm;
            end
            rv_decode_pkg::opc_auipc: begin
                wr_rd   = 1'b1;
                pc_src  = 1'b1;
                imm_sel = u_imm;
            end
            rv_decode_pkg::opc_jal: begin
                wr_rd   = 1'b1;
                jump    = 1'b1;
                pc_src  = 1'b1;
                imm_sel = j_imm;
            end
            rv_decode_pkg::opc_jalr: begin
                wr_rd   = 1'b1;
                jump    = 1'b1;
                imm_sel = i_imm;  // rs1 + offset
            end
            rv_decode_pkg::opc_branch: begin
                pc_src  = 1'b1;
                imm_sel = b_imm;
                br_sel  = rv_decode_pkg::br_cond_e'(funct3);
            end
            rv_decode_pkg::opc_load: begin
                wr_rd   = 1'b1;
                imm_sel = i_imm;
                alu_sel = rv_decode_pkg::alu_op_e'(funct3);
            end
            rv_decode_pkg::opc_store: begin
                imm_sel = s_imm;
                alu_sel = rv_decode_pkg::alu_op_e'(funct3);
            end
            rv_decode_pkg::opc_ari_itype: begin
                wr_rd   = 1'b1;
                imm_sel = i_imm;
                alu_sel = rv_decode_pkg::alu_op_e'(funct3);
            end
            rv_decode_pkg::opc_ari_rtype: begin
                wr_rd   = 1'b1;
                imm_src = 1'b0;
                alu_sel = rv_decode_pkg::alu_op_e'(funct3);
            end
            rv_decode_pkg::opc_csr: ;  // Passed on, no decode
            default: known = 1'b0;
        endcase
    end

    // Illegal or empty slot shows as all zeros
    assign valid       = in_val & known;
    assign inst_pc     = valid ? pc : '0;
    assign opcode      = valid ? rv_decode_pkg::opcode_e'(inst[6:0]) : rv_decode_pkg::opcode_e'(7'b0);
    assign rd          = valid ? inst[11:7] : '0;
    assign has_rd      = valid & wr_rd;
    assign rs1         = valid ? inst[19:15] : '0;
    assign rs2         = valid ? inst[24:20] : '0;
    assign src0_is_pc  = valid & pc_src;
    assign src1_is_imm = valid & imm_src;
    assign imm         = valid ? imm_sel : '0;
    assign alu_op      = valid ? alu_sel : rv_decode_pkg::add_sub;
    assign br_cond     = valid ? br_sel : rv_decode_pkg::beq;
    assign funct7      = valid ? inst[31:25] : '0;
    assign is_jump     = valid & jump;

endmodule

`default_nettype wire

// ==== src/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int xlen      = 32;  // Data and immediate
    localparam int addr_bits = 32;
    localparam int inst_bits = 32;
    localparam int reg_bits  = 5;

    // Pair queue sizing
    localparam int pair_queue_depth = 2;
    localparam int pair_ptr_bits    = $clog2(pair_queue_depth);
    localparam int pair_cnt_bits    = $clog2(pair_queue_depth + 1);

    // --------------------
    // Encodings
    // --------------------
    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_lui       = 7'b0110111,
        opc_auipc     = 7'b0010111,
        opc_jal       = 7'b1101111,
        opc_jalr      = 7'b1100111,
        opc_branch    = 7'b1100011,
        opc_load      = 7'b0000011,
        opc_store     = 7'b0100011,
        opc_ari_itype = 7'b0010011,
        opc_ari_rtype = 7'b0110011,
        opc_csr       = 7'b1110011
    } opcode_e;

    // ALU meaning of funct3
    typedef enum logic [2:0] {
        add_sub = 3'd0,
        sll     = 3'd1,
        slt     = 3'd2,
        sltu    = 3'd3,
        xor_op  = 3'd4,
        srl_sra = 3'd5,
        or_op   = 3'd6,
        and_op  = 3'd7
    } alu_op_e;

    // Branch funct3, codes 2 and 3 are unused
    typedef enum logic [2:0] {
        beq  = 3'd0,
        bne  = 3'd1,
        blt  = 3'd4,
        bge  = 3'd5,
        bltu = 3'd6,
        bgeu = 3'd7
    } br_cond_e;

endpackage

`default_nettype wire
